/* sources.f */
+incdir+hdl
hdl/sd_bmp_pkg.sv
hdl/sd_spi_reader.sv
hdl/bmp_photo_reader.sv
hdl/frame_buffer.sv
hdl/lcd_timing.sv
hdl/sd_bmp_lcd.sv
verif/sd_card_model.sv
verif/tb_sd_bmp_lcd.sv

/* Makefile */
TOP = tb_sd_bmp_lcd

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f sources.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sources.f -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

/* verif/tb_sd_bmp_lcd.sv */
// Testbench for the SD card BMP loader and LCD output
// Card model, reference pixels, display capture, checks and timeout
`default_nettype none
`timescale 1ns/1ps

`include "sd_bmp_config.svh"

module tb_sd_bmp_lcd;
    localparam int NPIX    = `H_DISP * `V_DISP;
    localparam int H_TOTAL = `H_SYNC + `H_BACK + `H_DISP + `H_FRONT;
    localparam int V_TOTAL = `V_SYNC + `V_BACK + `V_DISP + `V_FRONT;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    // Longest sector: command, 7 waits, R1, 7 waits, token, data, CRC
    localparam int SECTOR_CYCLES = (6 + 7 + 1 + 7 + 1 + 512 + 2) * 16 * `SPI_DIV + 16;
    localparam int LOAD_CYCLES   = `BMP_SECTORS * SECTOR_CYCLES + 2 * FRAME_CYCLES;
    localparam int CYCLE_LIMIT   = 2 * LOAD_CYCLES + 2 * FRAME_CYCLES + 100;

    logic        sys_clk;
    logic        reset;
    logic        sd_miso;
    logic        sd_clk;
    logic        sd_cs;
    logic        sd_mosi;
    logic        lcd_hs;
    logic        lcd_vs;
    logic        lcd_de;
    logic [23:0] lcd_rgb;
    logic        led;

    logic [15:0] image [NPIX];        // File order, row 0 at the bottom
    logic        cmd_seen;
    logic [5:0]  cmd_index;
    logic [31:0] cmd_addr;
    logic        cmd_framed;

    int check_count;
    int error_count;
    int cycle_count;
    int cmd_count;                    // Commands since reset
    int early_de;                     // de cycles before led
    int frames_seen;                  // vs falls since reset
    int lines;                        // Display lines in this frame
    int hs_pulses;                    // hs falls in this frame
    int x_pos;
    int pixel_count;
    logic prev_vs;
    logic prev_hs;
    logic prev_de;

    sd_bmp_lcd dut0 (
        .sys_clk (sys_clk),
        .reset   (reset),
        .sd_miso (sd_miso),
        .sd_clk  (sd_clk),
        .sd_cs   (sd_cs),
        .sd_mosi (sd_mosi),
        .lcd_hs  (lcd_hs),
        .lcd_vs  (lcd_vs),
        .lcd_de  (lcd_de),
        .lcd_rgb (lcd_rgb),
        .led     (led)
    );

    sd_card_model card0 (
        .sd_clk     (sd_clk),
        .sd_cs      (sd_cs),
        .sd_mosi    (sd_mosi),
        .sd_miso    (sd_miso),
        .image      (image),
        .cmd_seen   (cmd_seen),
        .cmd_index  (cmd_index),
        .cmd_addr   (cmd_addr),
        .cmd_framed (cmd_framed)
    );

    initial begin
        sys_clk = 1'b0;
        forever #5 sys_clk = ~sys_clk;
    end

    // ------------------------------------------------------------------------
    // Reference model and helpers
    // ------------------------------------------------------------------------
    // RGB565 hash of file row r and column c
    function automatic logic [15:0] ref_pixel(input int r, input int c);
        logic [31:0] h;
        h = (r * 32'h0000_9e37) ^ (c * 32'h0000_79b9) ^ 32'h0000_5a5a;
        h = h ^ (h >> 7) ^ (h << 3);
        return h[15:0];
    endfunction

    // 565 to 888, top bits repeated into the low end
    function automatic logic [23:0] expand_rgb(input logic [15:0] p);
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
        r = {p[15:11], p[15:13]};
        g = {p[10:5], p[10:9]};
        b = {p[4:0], p[4:2]};
        return {r, g, b};
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAIL %0t ns: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (error_count == errs_before) $display("test %s: ok", name);
        else $display("test %s: %0d errors", name, error_count - errs_before);
    endtask

    // Four reset cycles, outputs checked near the end
    task automatic apply_reset();
        reset = 1'b1;
        repeat (3) @(posedge sys_clk);
        @(negedge sys_clk);
        check_value("reset sd_cs", 32'(sd_cs), 32'd1);
        check_value("reset sd_clk", 32'(sd_clk), 32'd0);
        check_value("reset sd_mosi", 32'(sd_mosi), 32'd1);
        check_value("reset lcd_hs", 32'(lcd_hs), 32'd1);
        check_value("reset lcd_vs", 32'(lcd_vs), 32'd1);
        check_value("reset lcd_de", 32'(lcd_de), 32'd0);
        check_value("reset lcd_rgb", 32'(lcd_rgb), 32'd0);
        check_value("reset led", 32'(led), 32'd0);
        @(posedge sys_clk);
        #1 reset = 1'b0;
    endtask

    // One picture load, then two displayed frames
    task automatic run_load(input string name);
        int errs;
        errs = error_count;
        wait (led === 1'b1);
        @(negedge sys_clk);
        check_value("commands at load end", 32'(cmd_count), `BMP_SECTORS);
        check_value("sd_cs at load end", 32'(sd_cs), 32'd1);
        check_value("de cycles before led", 32'(early_de), 32'd0);
        report_test({name, " sector reads"}, errs);
        errs = error_count;
        wait (frames_seen >= 3);     // Third vs closes frame two
        @(negedge sys_clk);
        check_value("commands after display", 32'(cmd_count), `BMP_SECTORS);
        check_value("pixels in two frames", 32'(pixel_count), 32'(2 * NPIX));
        check_value("led held", 32'(led), 32'd1);
        report_test({name, " display"}, errs);
    endtask

    // ------------------------------------------------------------------------
    // Monitors
    // ------------------------------------------------------------------------
    always @(posedge cmd_seen or posedge reset) begin
        if (reset) begin
            cmd_count = 0;
        end else begin
            check_value("command index", 32'(cmd_index), 32'd17);
            check_value("command framing", 32'(cmd_framed), 32'd1);
            check_value("sector address", cmd_addr, `BMP_START_SECTOR + 32'(cmd_count));
            cmd_count++;
        end
    end

    // Display capture, outputs sampled mid-cycle
    always @(negedge sys_clk) begin
        if (reset) begin
            early_de    = 0;
            frames_seen = 0;
            lines       = 0;
            hs_pulses   = 0;
            x_pos       = 0;
            pixel_count = 0;
            prev_vs     = 1'b1;
            prev_hs     = 1'b1;
            prev_de     = 1'b0;
        end else begin
            if (lcd_de && !led) early_de++;
            if (prev_vs && !lcd_vs) begin              // Frame start
                if (frames_seen > 0) begin
                    check_value("lines per frame", 32'(lines), `V_DISP);
                    check_value("hs pulses per frame", 32'(hs_pulses), V_TOTAL);
                end
                frames_seen++;
                lines     = 0;
                hs_pulses = 0;
            end
            if (prev_hs && !lcd_hs) hs_pulses++;       // One per scan line
            if (lcd_de) begin
                // File rows are stored bottom-up
                check_value("pixel colour", 32'(lcd_rgb),
                            32'(expand_rgb(ref_pixel(`V_DISP - 1 - lines, x_pos))));
                pixel_count++;
                x_pos++;
            end else if (prev_de) begin                // Line end
                check_value("de cycles per line", 32'(x_pos), `H_DISP);
                lines++;
                x_pos = 0;
            end
            prev_vs = lcd_vs;
            prev_hs = lcd_hs;
            prev_de = lcd_de;
        end
    end

    // Run limit, two loads with longest waits plus frames
    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge sys_clk);
            cycle_count++;
        end
        $display("Timeout: run not finished after %0d cycles", CYCLE_LIMIT);
        $display("Simulation failed");
        $finish;
    end

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        int errs;
        reset = 1'b1;
        for (int k = 0; k < NPIX; k++) begin
            image[k] = ref_pixel(k / `H_DISP, k % `H_DISP);
        end
        apply_reset();
        run_load("first load");

        // Reset in the middle of a visible line
        do @(negedge sys_clk); while (!lcd_de);
        errs = error_count;
        @(posedge sys_clk);
        #1;
        apply_reset();
        report_test("reset mid display", errs);

        run_load("second load");     // Card waits differ this time

        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) $display("Simulation completed successfully");
        else $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/sd_card_model.sv */
// SPI mode SD card model answering CMD17 single-block reads
// Serves a BMP file image, random 0xFF wait bytes before R1 and token
`default_nettype none
`timescale 1ns/1ps

`include "sd_bmp_config.svh"

module sd_card_model (
    input  wire         sd_clk,
    input  wire         sd_cs,
    input  wire         sd_mosi,
    output logic        sd_miso,
    input  wire  [15:0] image [`H_DISP*`V_DISP],   // Pixels in file order
    output logic        cmd_seen,                  // Short pulse per command
    output logic [5:0]  cmd_index,
    output logic [31:0] cmd_addr,
    output logic        cmd_framed                 // Start and stop bits correct
);
    localparam int NPIX = `H_DISP * `V_DISP;

    logic [31:0] lfsr;
    logic [47:0] frame;      // Command as shifted in

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // Byte n of the BMP file
    function automatic logic [7:0] file_byte(input int n);
        int          k;
        logic [15:0] pix;
        if (n == 0) return 8'h42;                  // "BM" magic
        if (n == 1) return 8'h4D;
        if (n < `BMP_HEADER_BYTES) return 8'(n * 29 + 5);
        k = (n - `BMP_HEADER_BYTES) / 2;
        if (k >= NPIX) return 8'h00;               // Tail of the last sector
        pix = image[k];
        return ((n - `BMP_HEADER_BYTES) % 2 == 0) ? pix[7:0] : pix[15:8];
    endfunction

    // 0 to 7, one LFSR step per bit
    task automatic draw_waits(output int count);
        count = 0;
        repeat (3) begin
            lfsr  = lfsr_step(lfsr);
            count = (count << 1) | int'(lfsr[0]);
        end
    endtask

    // MSB first, changed after the falling edge
    task automatic send_byte(input logic [7:0] b);
        for (int i = 7; i >= 0; i--) begin
            @(negedge sd_clk);
            #1 sd_miso = b[i];
        end
    endtask

    initial begin
        int waits;
        int base;
        lfsr       = 32'h8e4e_b5cf;
        sd_miso    = 1'b1;
        cmd_seen   = 1'b0;
        cmd_index  = 6'd0;
        cmd_addr   = 32'd0;
        cmd_framed = 1'b0;
        forever begin
            wait (sd_cs === 1'b0);
            repeat (48) begin
                @(posedge sd_clk);
                frame = {frame[46:0], sd_mosi};
            end
            cmd_index  = frame[45:40];
            cmd_addr   = frame[39:8];
            cmd_framed = (frame[47:46] == 2'b01) && frame[0];
            if (cmd_index != 6'd17)
                $display("Card model: unexpected command %0d at %0t", cmd_index, $time);
            #1 cmd_seen = 1'b1;
            #1 cmd_seen = 1'b0;
            draw_waits(waits);
            repeat (waits) send_byte(8'hFF);
            send_byte(8'h00);                      // R1, card ready
            draw_waits(waits);
            repeat (waits) send_byte(8'hFF);
            send_byte(8'hFE);                      // Start block token
            base = int'(cmd_addr - `BMP_START_SECTOR) * 512;
            for (int i = 0; i < 512; i++) begin
                send_byte(file_byte(base + i));
            end
            send_byte(8'hA5);                      // CRC, ignored by the reader
            send_byte(8'h5A);
            @(negedge sd_clk);
            #1 sd_miso = 1'b1;
            wait (sd_cs === 1'b1);
        end
    end

endmodule

`default_nettype wire

/* hdl/sd_bmp_lcd.sv */
// Top level, SD card BMP loader feeding an RGB LCD
// Sector reader, photo reader, frame buffer and panel timing
`default_nettype none
`timescale 1ns/1ps

`include "sd_bmp_config.svh"

module sd_bmp_lcd (
    input  wire         sys_clk,
    input  wire         reset,
    // SD card, SPI mode
    input  wire         sd_miso,
    output logic        sd_clk,
    output logic        sd_cs,
    output logic        sd_mosi,
    // RGB panel
    output logic        lcd_hs,
    output logic        lcd_vs,
    output logic        lcd_de,
    output logic [23:0] lcd_rgb,
    output logic        led         // Picture loaded
);
    import sd_bmp_pkg::*;

    sd_rd_req_t            rd_req;
    sd_rd_word_t           rd_word;
    fb_write_t             fb_wr;
    logic                  rd_busy;
    logic                  frame_loaded;
    logic [`FB_ADDR_W-1:0] rd_addr;
    logic [15:0]           rd_pixel;

    // ------------------------------------------------------------------------
    // Load path
    // ------------------------------------------------------------------------
    sd_spi_reader u_sd_spi_reader (
        .sys_clk (sys_clk),
        .reset   (reset),
        .req     (rd_req),
        .sd_miso (sd_miso),
        .sd_clk  (sd_clk),
        .sd_cs   (sd_cs),
        .sd_mosi (sd_mosi),
        .rd_busy (rd_busy),
        .word    (rd_word)
    );

    bmp_photo_reader u_bmp_photo_reader (
        .sys_clk      (sys_clk),
        .reset        (reset),
        .rd_busy      (rd_busy),
        .word         (rd_word),
        .req          (rd_req),
        .fb_wr        (fb_wr),
        .frame_loaded (frame_loaded)
    );

    // Display path
    frame_buffer u_frame_buffer (
        .sys_clk  (sys_clk),
        .fb_wr    (fb_wr),
        .rd_addr  (rd_addr),
        .rd_pixel (rd_pixel)
    );

    lcd_timing u_lcd_timing (
        .sys_clk  (sys_clk),
        .reset    (reset),
        .enable   (frame_loaded),    // Scan starts once the picture is in
        .rd_addr  (rd_addr),
        .rd_pixel (rd_pixel),
        .lcd_hs   (lcd_hs),
        .lcd_vs   (lcd_vs),
        .lcd_de   (lcd_de),
        .lcd_rgb  (lcd_rgb)
    );

    assign led = frame_loaded;

endmodule

`default_nettype wire

/* hdl/lcd_timing.sv */
// RGB panel timing generator
// hs/vs/de counters, frame buffer fetch one cycle ahead, RGB565 to RGB888
`default_nettype none
`timescale 1ns/1ps

`include "sd_bmp_config.svh"

module lcd_timing (
    input  wire                  sys_clk,
    input  wire                  reset,
    input  wire                  enable,     // Picture loaded
    output logic [`FB_ADDR_W-1:0] rd_addr,
    input  wire [15:0]           rd_pixel,
    output logic                 lcd_hs,
    output logic                 lcd_vs,
    output logic                 lcd_de,
    output logic [23:0]          lcd_rgb
);
    import sd_bmp_pkg::*;

    localparam int H_TOTAL = `H_SYNC + `H_BACK + `H_DISP + `H_FRONT;
    localparam int V_TOTAL = `V_SYNC + `V_BACK + `V_DISP + `V_FRONT;
    localparam int H_W     = $clog2(H_TOTAL);
    localparam int V_W     = $clog2(V_TOTAL);

    localparam logic [H_W-1:0] H_SYNC_END = H_W'(`H_SYNC);
    localparam logic [H_W-1:0] H_ACT0     = H_W'(`H_SYNC + `H_BACK);
    localparam logic [H_W-1:0] H_ACT1     = H_W'(`H_SYNC + `H_BACK + `H_DISP);
    localparam logic [H_W-1:0] H_LAST     = H_W'(H_TOTAL - 1);
    localparam logic [V_W-1:0] V_SYNC_END = V_W'(`V_SYNC);
    localparam logic [V_W-1:0] V_ACT0     = V_W'(`V_SYNC + `V_BACK);
    localparam logic [V_W-1:0] V_ACT1     = V_W'(`V_SYNC + `V_BACK + `V_DISP);
    localparam logic [V_W-1:0] V_LAST     = V_W'(V_TOTAL - 1);

    localparam lcd_sync_t SYNC_IDLE = '{hs: 1'b1, vs: 1'b1, de: 1'b0};

    logic [H_W-1:0] h_cnt;
    logic [V_W-1:0] v_cnt;
    lcd_sync_t      sync_now;         // Fetch stage
    lcd_sync_t      sync_q;           // Aligned with rd_pixel

    // ------------------------------------------------------------------------
    // Scan counters, held at the origin until the picture is in
    // ------------------------------------------------------------------------
    always_ff @(posedge sys_clk) begin
        if (reset || !enable) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == H_LAST) begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    always_comb begin
        sync_now = SYNC_IDLE;
        if (enable) begin
            sync_now.hs = (h_cnt >= H_SYNC_END);
            sync_now.vs = (v_cnt >= V_SYNC_END);
            sync_now.de = (h_cnt >= H_ACT0) && (h_cnt < H_ACT1) &&
                          (v_cnt >= V_ACT0) && (v_cnt < V_ACT1);
        end
    end

    // Linear address of the pixel shown next cycle
    assign rd_addr = sync_now.de ?
        `FB_ADDR_W'(int'(v_cnt - V_ACT0) * `H_DISP + int'(h_cnt - H_ACT0)) : '0;

    always_ff @(posedge sys_clk) begin
        if (reset) sync_q <= SYNC_IDLE;
        else       sync_q <= sync_now;
    end

    assign lcd_hs = sync_q.hs;
    assign lcd_vs = sync_q.vs;
    assign lcd_de = sync_q.de;

    // Widen by repeating the top bits, black outside the active area
    assign lcd_rgb = sync_q.de ?
        {rd_pixel[15:11], rd_pixel[15:13],
         rd_pixel[10:5],  rd_pixel[10:9],
         rd_pixel[4:0],   rd_pixel[4:2]} : 24'd0;

endmodule

`default_nettype wire

/* hdl/frame_buffer.sv */
// Pixel frame store, simple dual-port RAM
// One write port from the loader, one registered read port for the panel
`default_nettype none
`timescale 1ns/1ps

`include "sd_bmp_config.svh"

module frame_buffer (
    input  wire                        sys_clk,
    input  wire sd_bmp_pkg::fb_write_t fb_wr,
    input  wire [`FB_ADDR_W-1:0]       rd_addr,
    output logic [15:0]                rd_pixel
);
    localparam int DEPTH = `H_DISP * `V_DISP;

    logic [15:0] mem [DEPTH];         // RGB565, display line order

    // ------------------------------------------------------------------------
    // Write port
    // ------------------------------------------------------------------------
    always_ff @(posedge sys_clk) begin
        if (fb_wr.we) begin
            mem[fb_wr.addr] <= fb_wr.pixel;
        end
    end

    // Read port, data one cycle after the address
    always_ff @(posedge sys_clk) begin
        rd_pixel <= mem[rd_addr];
    end

endmodule

`default_nettype wire

/* hdl/bmp_photo_reader.sv */
// BMP loader, requests sectors in order and skips the file header
// Writes RGB565 pixels with rows flipped, since BMP stores them bottom-up
`default_nettype none
`timescale 1ns/1ps

`include "sd_bmp_config.svh"

module bmp_photo_reader (
    input  wire                          sys_clk,
    input  wire                          reset,
    input  wire                          rd_busy,
    input  wire sd_bmp_pkg::sd_rd_word_t word,
    output sd_bmp_pkg::sd_rd_req_t       req,
    output sd_bmp_pkg::fb_write_t        fb_wr,
    output logic                         frame_loaded
);
    localparam int HDR_WORDS = `BMP_HEADER_BYTES / 2;
    localparam int SKIP_W    = $clog2(HDR_WORDS + 1);
    localparam int SEC_W     = $clog2(`BMP_SECTORS + 1);
    localparam int COL_W     = $clog2(`H_DISP);
    localparam int ROW_W     = $clog2(`V_DISP);

    typedef enum logic [1:0] {PR_ISSUE, PR_WAIT_RISE, PR_WAIT_FALL, PR_DONE} pr_state_e;

    pr_state_e             state;
    logic [SEC_W-1:0]      sec_cnt;
    logic                  req_start;
    logic [31:0]           req_addr;
    logic [SKIP_W-1:0]     skip_cnt;   // Header words seen
    logic [COL_W-1:0]      col;
    logic [ROW_W-1:0]      row;        // File row, 0 is the bottom line
    logic                  pix_done;
    logic                  wr_en;
    logic [`FB_ADDR_W-1:0] wr_addr;
    logic [15:0]           wr_pixel;

    // ------------------------------------------------------------------------
    // Sector sequencer
    // ------------------------------------------------------------------------
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            state        <= PR_ISSUE;
            sec_cnt      <= '0;
            req_start    <= 1'b0;
            frame_loaded <= 1'b0;
        end else begin
            req_start <= 1'b0;
            case (state)
                PR_ISSUE: if (!rd_busy) begin
                    req_start <= 1'b1;
                    req_addr  <= `BMP_START_SECTOR + 32'(sec_cnt);
                    state     <= PR_WAIT_RISE;
                end
                PR_WAIT_RISE: if (rd_busy) state <= PR_WAIT_FALL;
                PR_WAIT_FALL: if (!rd_busy) begin  // Sector complete
                    if (sec_cnt == SEC_W'(`BMP_SECTORS - 1)) begin
                        state        <= PR_DONE;
                        frame_loaded <= 1'b1;
                    end else begin
                        sec_cnt <= sec_cnt + 1'b1;
                        state   <= PR_ISSUE;
                    end
                end
                default: state <= PR_DONE;     // Holds until reset
            endcase
        end
    end

    // Pixel path, one write per accepted word
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            skip_cnt <= '0;
            col      <= '0;
            row      <= '0;
            pix_done <= 1'b0;
            wr_en    <= 1'b0;
        end else begin
            wr_en <= 1'b0;
            if (word.valid) begin
                if (skip_cnt != SKIP_W'(HDR_WORDS)) begin
                    skip_cnt <= skip_cnt + 1'b1;
                end else if (!pix_done) begin   // Padding after the image dropped
                    wr_en    <= 1'b1;
                    wr_addr  <= `FB_ADDR_W'((`V_DISP - 1 - int'(row)) * `H_DISP + int'(col));
                    wr_pixel <= word.data;
                    if (col == COL_W'(`H_DISP - 1)) begin
                        col <= '0;
                        if (row == ROW_W'(`V_DISP - 1)) pix_done <= 1'b1;
                        else row <= row + 1'b1;
                    end else begin
                        col <= col + 1'b1;
                    end
                end
            end
        end
    end

    assign req   = '{start: req_start, addr: req_addr};
    assign fb_wr = '{we: wr_en, addr: wr_addr, pixel: wr_pixel};

    // Picture flagged only once every pixel is in
    a_load_after_pixels: assert property (@(posedge sys_clk) disable iff (reset)
        frame_loaded |-> pix_done);

endmodule

`default_nettype wire

/* hdl/sd_spi_reader.sv */
// SPI mode single-block read engine (CMD17)
// Sends the command, waits for R1 and the data token, streams 16-bit words
`default_nettype none
`timescale 1ns/1ps

`include "sd_bmp_config.svh"

module sd_spi_reader (
    input  wire                         sys_clk,
    input  wire                         reset,
    input  wire sd_bmp_pkg::sd_rd_req_t req,
    input  wire                         sd_miso,
    output logic                        sd_clk,
    output logic                        sd_cs,
    output logic                        sd_mosi,
    output logic                        rd_busy,
    output sd_bmp_pkg::sd_rd_word_t     word
);
    import sd_bmp_pkg::*;

    sd_state_e   state;
    logic [7:0]  div_cnt;      // Half period counter
    logic        tick;         // sd_clk toggles this cycle
    logic        rise;
    logic        fall;
    logic [2:0]  bit_cnt;
    logic [8:0]  byte_cnt;     // Command, data or CRC byte index
    logic        byte_end;     // Eighth bit sampled
    logic [47:0] tx_shift;
    logic [7:0]  rx_shift;
    logic [7:0]  rx_byte;
    logic [7:0]  low_byte;
    logic        word_valid;
    logic [15:0] word_data;
    logic [47:0] cmd_frame;

    // Start bits, opcode, block address, dummy CRC
    assign cmd_frame = {2'b01, CMD_READ_SINGLE, req.addr, 8'hFF};

    assign tick     = (state != ST_IDLE) && (div_cnt == 8'(`SPI_DIV - 1));
    assign rise     = tick && !sd_clk;
    assign fall     = tick && sd_clk;
    assign rx_byte  = {rx_shift[6:0], sd_miso};
    assign byte_end = rise && (bit_cnt == 3'd7);

    // ------------------------------------------------------------------------
    // SPI clock, idles low between transfers
    // ------------------------------------------------------------------------
    always_ff @(posedge sys_clk) begin
        if (reset || state == ST_IDLE) begin
            div_cnt <= 8'd0;
            sd_clk  <= 1'b0;
        end else if (tick) begin
            div_cnt <= 8'd0;
            sd_clk  <= ~sd_clk;
        end else begin
            div_cnt <= div_cnt + 8'd1;
        end
    end

    // MOSI changes on fall, MISO sampled on rise
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            tx_shift <= '1;                      // MOSI idles high
            rx_shift <= 8'd0;
            bit_cnt  <= 3'd0;
        end else begin
            if (state == ST_IDLE && req.start) begin
                tx_shift <= cmd_frame;           // MSB on the line before first rise
                bit_cnt  <= 3'd0;
            end else if (fall) begin
                tx_shift <= {tx_shift[46:0], 1'b1};
            end
            if (rise) begin
                rx_shift <= rx_byte;
                bit_cnt  <= bit_cnt + 3'd1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Transfer sequence
    // ------------------------------------------------------------------------
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            state      <= ST_IDLE;
            sd_cs      <= 1'b1;
            byte_cnt   <= 9'd0;
            word_valid <= 1'b0;
        end else begin
            word_valid <= 1'b0;
            case (state)
                ST_IDLE: if (req.start) begin
                    state    <= ST_SEND_CMD;
                    sd_cs    <= 1'b0;
                    byte_cnt <= 9'd0;
                end
                ST_SEND_CMD: if (byte_end) begin
                    if (byte_cnt == 9'd5) begin  // Six command bytes out
                        state    <= ST_WAIT_R1;
                        byte_cnt <= 9'd0;
                    end else begin
                        byte_cnt <= byte_cnt + 9'd1;
                    end
                end
                ST_WAIT_R1: if (byte_end && rx_byte == 8'h00) begin
                    state <= ST_WAIT_TOKEN;
                end
                ST_WAIT_TOKEN: if (byte_end && rx_byte == 8'hFE) begin
                    state <= ST_DATA;
                end
                ST_DATA: if (byte_end) begin
                    if (!byte_cnt[0]) begin
                        low_byte <= rx_byte;
                    end else begin
                        word_valid <= 1'b1;
                        word_data  <= {rx_byte, low_byte};
                    end
                    if (byte_cnt == 9'd511) begin
                        state    <= ST_CRC;
                        byte_cnt <= 9'd0;
                    end else begin
                        byte_cnt <= byte_cnt + 9'd1;
                    end
                end
                ST_CRC: if (byte_end) begin
                    if (byte_cnt == 9'd1) state <= ST_DONE;  // CRC discarded
                    else byte_cnt <= byte_cnt + 9'd1;
                end
                ST_DONE: if (fall) begin         // Finish the last clock low
                    state <= ST_IDLE;
                    sd_cs <= 1'b1;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    assign sd_mosi = tx_shift[47];
    assign rd_busy = (state != ST_IDLE);
    assign word    = '{valid: word_valid, data: word_data};

    // Requester must wait for the previous sector
    a_start_idle: assert property (@(posedge sys_clk) disable iff (reset)
        req.start |-> !rd_busy);
    a_cs_idle: assert property (@(posedge sys_clk) disable iff (reset)
        state == ST_IDLE |-> sd_cs);

endmodule

`default_nettype wire

/* hdl/sd_bmp_pkg.sv */
// Shared types for the picture loader
// SD command opcodes, sector reader states, inter-block structs
`default_nettype none

`include "sd_bmp_config.svh"

package sd_bmp_pkg;

    // SD command index, sent as 0x40 | index
    typedef enum logic [5:0] {
        CMD_GO_IDLE     = 6'd0,
        CMD_READ_SINGLE = 6'd17
    } sd_cmd_e;

    // Sector reader FSM
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SEND_CMD,
        ST_WAIT_R1,
        ST_WAIT_TOKEN,
        ST_DATA,
        ST_CRC,
        ST_DONE
    } sd_state_e;

    typedef struct packed {
        logic                  we;
        logic [`FB_ADDR_W-1:0] addr;
        logic [15:0]           pixel;     // RGB565
    } fb_write_t;

    typedef struct packed {
        logic        start;               // One-cycle pulse
        logic [31:0] addr;                // Block address
    } sd_rd_req_t;

    typedef struct packed {
        logic        valid;               // One pulse per byte pair
        logic [15:0] data;                // First byte in low half
    } sd_rd_word_t;

    typedef struct packed {
        logic hs;                         // Active low
        logic vs;                         // Active low
        logic de;
    } lcd_sync_t;

endpackage

`default_nettype wire

/* hdl/sd_bmp_config.svh */
// Build-time constants for the SD card picture loader
// Panel geometry, sync widths, SPI clock divider, BMP file layout
`ifndef SD_BMP_CONFIG_SVH
`define SD_BMP_CONFIG_SVH

// Active area
`define H_DISP            32    // Pixels per line
`define V_DISP            16    // Lines per frame

// Horizontal timing in pixel clocks
`define H_SYNC            2
`define H_BACK            3
`define H_FRONT           2

// Vertical timing in lines
`define V_SYNC            1
`define V_BACK            2
`define V_FRONT           1

`define SPI_DIV           2       // sys_clk cycles per sd_clk half period
`define BMP_START_SECTOR  32'd100 // First sector of the file on the card
`define BMP_HEADER_BYTES  54
`define BMP_SECTORS       3       // 54 + 32*16*2 bytes round up to 3 sectors
`define FB_ADDR_W         9       // 32*16 = 512 words

`endif
